/* Makefile */
VERILATOR ?= verilator
TOP       ?= vReadTb
FILELIST  ?= vReadTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

/* source/addrGen.sv */
module addrGen #(
   parameter int ADDR_W = 6
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  logic [ADDR_W-1:0] start,
   input  logic [ADDR_W-1:0] iterations,
   input  vReadPkg::periodT  period,
   input  vReadPkg::periodT  duty,
   input  vReadPkg::periodT  delay,
   input  logic [ADDR_W-1:0] shift,
   input  logic [ADDR_W-1:0] incr,
   output logic [ADDR_W-1:0] addr,
   output logic              memEn,
   output logic              done
);

   vReadPkg::genStateT state;
   vReadPkg::periodT   delayCnt;
   vReadPkg::periodT   perCnt;
   logic [ADDR_W-1:0]  iterCnt;
   vReadPkg::periodT   periodReg;
   vReadPkg::periodT   dutyReg;
   logic [ADDR_W-1:0]  iterReg;
   logic [ADDR_W-1:0]  shiftReg;
   logic [ADDR_W-1:0]  incrReg;
   logic               periodEnd;
   logic               lastIter;
   logic               emptyRun;

   assign memEn     = (state == vReadPkg::ACTIVE) && (perCnt < dutyReg);
   assign periodEnd = (perCnt == periodReg - 1'b1);
   assign lastIter  = (iterCnt == iterReg - 1'b1);
   assign emptyRun  = (iterations == '0) || (period == '0);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= vReadPkg::IDLE;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         addr     <= '0;
         done     <= 1'b1;
      end
      else if (run)
      begin
         if (emptyRun)
         begin
            state <= vReadPkg::IDLE;
         end
         else
         begin
            state <= (delay == '0) ? vReadPkg::ACTIVE : vReadPkg::DELAY;
         end
         delayCnt <= delay;
         perCnt   <= '0;
         iterCnt  <= '0;
         addr     <= start;
         done     <= emptyRun;
      end
      else
      begin
         case (state)
            vReadPkg::DELAY:
            begin
               delayCnt <= delayCnt - 1'b1;
               if (delayCnt == 6'd1)
               begin
                  state <= vReadPkg::ACTIVE;
               end
            end
            vReadPkg::ACTIVE:
            begin
               // incr per enabled cycle, shift at period end
               addr <= addr + (memEn ? incrReg : '0) + (periodEnd ? shiftReg : '0);
               if (periodEnd)
               begin
                  perCnt  <= '0;
                  iterCnt <= iterCnt + 1'b1;
                  if (lastIter)
                  begin
                     state <= vReadPkg::IDLE;
                     done  <= 1'b1;
                  end
               end
               else
               begin
                  perCnt <= perCnt + 1'b1;
               end
            end
            default:
            begin
               state <= vReadPkg::IDLE;
            end
         endcase
      end
   end

   // pattern config latched on run
   always_ff @(posedge clk)
   begin
      if (run)
      begin
         periodReg <= period;
         dutyReg   <= duty;
         iterReg   <= iterations;
         shiftReg  <= shift;
         incrReg   <= incr;
      end
   end

endmodule

/* source/busArbiter.sv */
module busArbiter #(
   parameter int NUM_LANES = 3
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [NUM_LANES-1:0] busValid,
   input  vReadPkg::extAddrT    busAddr [NUM_LANES],
   input  logic                 memReady,
   output logic [NUM_LANES-1:0] busReady,
   output logic                 memValid,
   output vReadPkg::extAddrT    memAddr
);

   localparam int GRANT_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic [GRANT_W-1:0] grant;
   logic [GRANT_W-1:0] nextGrant;
   logic               hold;

   assign memValid = busValid[grant];
   assign memAddr  = busAddr[grant];

   // request waiting on ready keeps the grant
   assign hold = memValid && !memReady;

   always_comb
   begin
      int  idx;
      logic found;
      nextGrant = grant;
      found     = 1'b0;
      // first requester after the current one
      for (int k = 1; k <= NUM_LANES; k++)
      begin
         idx = (int'(grant) + k) % NUM_LANES;
         if (!found && busValid[idx])
         begin
            nextGrant = GRANT_W'(idx);
            found     = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         grant <= '0;
      end
      else if (!hold)
      begin
         grant <= nextGrant;
      end
   end

   always_comb
   begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
         busReady[i] = memReady && (grant == GRANT_W'(i));
      end
   end

endmodule

/* source/dualPortRam.sv */
module dualPortRam #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 6
)
(
   input  logic              clk,
   input  logic              wrEn,
   input  logic [ADDR_W-1:0] wrAddr,
   input  logic [DATA_W-1:0] wrData,
   input  logic              rdEn,
   input  logic [ADDR_W-1:0] rdAddr,
   output logic [DATA_W-1:0] rdData
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk)
   begin
      if (wrEn)
      begin
         mem[wrAddr] <= wrData;
      end
      // read data holds when not enabled
      if (rdEn)
      begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

/* source/extAddrGen.sv */
module extAddrGen #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 6
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  vReadPkg::extAddrT extAddr,
   input  logic [ADDR_W-1:0] intAddr,
   input  vReadPkg::sizeT    size,
   input  logic              busReady,
   input  logic [DATA_W-1:0] busRdata,
   output logic              busValid,
   output vReadPkg::extAddrT busAddr,
   output logic              memWrEn,
   output logic [ADDR_W-1:0] memWrAddr,
   output logic [DATA_W-1:0] memWrData,
   output logic              done
);

   vReadPkg::genStateT state;
   vReadPkg::sizeT     count;
   vReadPkg::sizeT     sizeReg;
   logic [ADDR_W-1:0]  intBase;
   logic               accept;
   logic               lastWord;

   assign busValid = (state == vReadPkg::ACTIVE);
   assign accept   = busValid && busReady;
   assign lastWord = (count == sizeReg - 1'b1);

   // returned word goes straight into the buffer
   assign memWrEn   = accept;
   assign memWrAddr = intBase + ADDR_W'(count);
   assign memWrData = busRdata;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= vReadPkg::IDLE;
         count   <= '0;
         busAddr <= '0;
         done    <= 1'b1;
      end
      else if (run)
      begin
         state   <= (size != '0) ? vReadPkg::ACTIVE : vReadPkg::IDLE;
         count   <= '0;
         busAddr <= extAddr;
         done    <= (size == '0);
      end
      else if (accept)
      begin
         // address only moves on a completed transfer
         count   <= count + 1'b1;
         busAddr <= busAddr + 1'b1;
         if (lastWord)
         begin
            state <= vReadPkg::IDLE;
            done  <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (run)
      begin
         sizeReg <= size;
         intBase <= intAddr;
      end
   end

endmodule

/* source/readCollector.sv */
module readCollector #(
   parameter int NUM_LANES = 3,
   parameter int DATA_W    = 32
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   input  logic [DATA_W-1:0]    laneData [NUM_LANES],
   input  logic [NUM_LANES-1:0] laneValid,
   input  logic [NUM_LANES-1:0] laneDone,
   output logic [DATA_W-1:0]    outData [NUM_LANES],
   output logic [NUM_LANES-1:0] outValid,
   output logic                 done
);

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
         outData[i] <= laneData[i];
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         outValid <= '0;
         done     <= 1'b1;
      end
      else
      begin
         outValid <= laneValid;
         // low from the cycle after run until every lane ends
         done     <= run ? 1'b0 : &laneDone;
      end
   end

endmodule

/* source/vRead.sv */
module vRead #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 6
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  vReadPkg::extAddrT extAddr,
   input  logic [ADDR_W-1:0] intAddr,
   input  vReadPkg::sizeT    size,
   input  logic              pingPong,
   input  logic [ADDR_W-1:0] startB,
   input  logic [ADDR_W-1:0] iterB,
   input  vReadPkg::periodT  perB,
   input  vReadPkg::periodT  dutyB,
   input  vReadPkg::periodT  delayB,
   input  logic [ADDR_W-1:0] shiftB,
   input  logic [ADDR_W-1:0] incrB,
   input  logic              reverseB,
   input  logic              busReady,
   input  logic [DATA_W-1:0] busRdata,
   output logic              busValid,
   output vReadPkg::extAddrT busAddr,
   output logic [DATA_W-1:0] laneData,
   output logic              laneValid,
   output logic              laneDone
);

   logic              ppState;
   logic [ADDR_W-1:0] fetchAddr;
   logic              wrEn;
   logic [ADDR_W-1:0] wrAddr;
   logic [DATA_W-1:0] wrData;
   logic              fetchDone;
   logic [ADDR_W-1:0] genAddr;
   logic [ADDR_W-1:0] revAddr;
   logic [ADDR_W-1:0] rdAddr;
   logic              rdEn;
   logic              readDone;

   function automatic logic [ADDR_W-1:0] reverseBits(input logic [ADDR_W-1:0] word);
      logic [ADDR_W-1:0] res;
      for (int i = 0; i < ADDR_W; i++)
      begin
         res[i] = word[ADDR_W-1-i];
      end
      return res;
   endfunction

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ppState <= 1'b0;
      end
      else if (run)
      begin
         ppState <= pingPong ? !ppState : 1'b0;
      end
   end

   // fetcher latches this on run, before the toggle
   assign fetchAddr = pingPong ? {ppState, intAddr[ADDR_W-2:0]} : intAddr;

   // after the toggle ppState points at the half filled last run
   assign revAddr = reverseB ? reverseBits(genAddr) : genAddr;
   assign rdAddr  = pingPong ? {ppState, revAddr[ADDR_W-2:0]} : revAddr;

   extAddrGen #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_extAddrGen (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .extAddr  (extAddr),
      .intAddr  (fetchAddr),
      .size     (size),
      .busReady (busReady),
      .busRdata (busRdata),
      .busValid (busValid),
      .busAddr  (busAddr),
      .memWrEn  (wrEn),
      .memWrAddr(wrAddr),
      .memWrData(wrData),
      .done     (fetchDone)
   );

   addrGen #(
      .ADDR_W(ADDR_W)
   ) u_addrGen (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .start     (startB),
      .iterations(iterB),
      .period    (perB),
      .duty      (dutyB),
      .delay     (delayB),
      .shift     (shiftB),
      .incr      (incrB),
      .addr      (genAddr),
      .memEn     (rdEn),
      .done      (readDone)
   );

   dualPortRam #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_dualPortRam (
      .clk   (clk),
      .wrEn  (wrEn),
      .wrAddr(wrAddr),
      .wrData(wrData),
      .rdEn  (rdEn),
      .rdAddr(rdAddr),
      .rdData(laneData)
   );

   // ram read takes one cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         laneValid <= 1'b0;
      end
      else
      begin
         laneValid <= rdEn;
      end
   end

   assign laneDone = fetchDone & readDone;

endmodule

/* source/vReadPkg.sv */
package vReadPkg;

   // external word address
   localparam int EXT_ADDR_W = 16;

   // period, duty and delay counters
   localparam int PERIOD_W = 6;

   // fetch length in words
   localparam int SIZE_W = 10;

   typedef logic [EXT_ADDR_W-1:0] extAddrT;
   typedef logic [PERIOD_W-1:0]   periodT;
   typedef logic [SIZE_W-1:0]     sizeT;

   // shared by the fetcher and the pattern generator
   typedef enum logic [1:0]
   {
      IDLE   = 2'd0,
      DELAY  = 2'd1,
      ACTIVE = 2'd2
   } genStateT;

endpackage

/* source/vReadTop.sv */
module vReadTop #(
   parameter int NUM_LANES = 3,
   parameter int DATA_W    = 32,
   parameter int ADDR_W    = 6
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   input  vReadPkg::extAddrT    extAddr  [NUM_LANES],
   input  logic [ADDR_W-1:0]    intAddr  [NUM_LANES],
   input  vReadPkg::sizeT       size     [NUM_LANES],
   input  logic [ADDR_W-1:0]    iterA    [NUM_LANES],
   input  logic [ADDR_W-1:0]    shiftA   [NUM_LANES],
   input  logic [ADDR_W-1:0]    incrA    [NUM_LANES],
   input  logic                 pingPong [NUM_LANES],
   input  logic [ADDR_W-1:0]    startB   [NUM_LANES],
   input  logic [ADDR_W-1:0]    iterB    [NUM_LANES],
   input  vReadPkg::periodT     perB     [NUM_LANES],
   input  vReadPkg::periodT     dutyB    [NUM_LANES],
   input  vReadPkg::periodT     delayB   [NUM_LANES],
   input  logic [ADDR_W-1:0]    shiftB   [NUM_LANES],
   input  logic [ADDR_W-1:0]    incrB    [NUM_LANES],
   input  logic                 reverseB [NUM_LANES],
   output logic                 memValid,
   output vReadPkg::extAddrT    memAddr,
   input  logic                 memReady,
   input  logic [DATA_W-1:0]    memRdata,
   output logic [DATA_W-1:0]    outData  [NUM_LANES],
   output logic [NUM_LANES-1:0] outValid,
   output logic                 done
);

   logic [NUM_LANES-1:0] busValid;
   vReadPkg::extAddrT    busAddr [NUM_LANES];
   logic [NUM_LANES-1:0] busReady;
   logic [DATA_W-1:0]    laneData [NUM_LANES];
   logic [NUM_LANES-1:0] laneValid;
   logic [NUM_LANES-1:0] laneDone;

   busArbiter #(
      .NUM_LANES(NUM_LANES)
   ) u_busArbiter (
      .clk     (clk),
      .rst     (rst),
      .busValid(busValid),
      .busAddr (busAddr),
      .memReady(memReady),
      .busReady(busReady),
      .memValid(memValid),
      .memAddr (memAddr)
   );

   // fetch is a linear block with no outer pattern
   for (genvar i = 0; i < NUM_LANES; i++)
   begin : gLane
      vRead #(
         .DATA_W(DATA_W),
         .ADDR_W(ADDR_W)
      ) u_vRead (
         .clk      (clk),
         .rst      (rst),
         .run      (run),
         .extAddr  (extAddr[i]),
         .intAddr  (intAddr[i]),
         .size     (size[i]),
         .pingPong (pingPong[i]),
         .startB   (startB[i]),
         .iterB    (iterB[i]),
         .perB     (perB[i]),
         .dutyB    (dutyB[i]),
         .delayB   (delayB[i]),
         .shiftB   (shiftB[i]),
         .incrB    (incrB[i]),
         .reverseB (reverseB[i]),
         .busReady (busReady[i]),
         .busRdata (memRdata),
         .busValid (busValid[i]),
         .busAddr  (busAddr[i]),
         .laneData (laneData[i]),
         .laneValid(laneValid[i]),
         .laneDone (laneDone[i])
      );
   end

   readCollector #(
      .NUM_LANES(NUM_LANES),
      .DATA_W   (DATA_W)
   ) u_readCollector (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .laneData (laneData),
      .laneValid(laneValid),
      .laneDone (laneDone),
      .outData  (outData),
      .outValid (outValid),
      .done     (done)
   );

endmodule

/* vReadTop.f */
source/vReadPkg.sv
source/dualPortRam.sv
source/extAddrGen.sv
source/addrGen.sv
source/vRead.sv
source/busArbiter.sv
source/readCollector.sv
source/vReadTop.sv
verif/vReadTb_assert.sv
verif/vReadTb.sv

/* verif/vReadTb.sv */
module vReadTb;

   localparam int NUM_LANES  = 3;
   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 6;
   localparam int DEPTH      = 2**ADDR_W;
   localparam int NUM_RUNS   = 20;
   localparam int MAX_CYCLES = NUM_RUNS * 600;

   logic                 clk;
   logic                 rst;
   logic                 run;
   vReadPkg::extAddrT    extAddr  [NUM_LANES];
   logic [ADDR_W-1:0]    intAddr  [NUM_LANES];
   vReadPkg::sizeT       size     [NUM_LANES];
   logic [ADDR_W-1:0]    iterA    [NUM_LANES];
   logic [ADDR_W-1:0]    shiftA   [NUM_LANES];
   logic [ADDR_W-1:0]    incrA    [NUM_LANES];
   logic                 pingPong [NUM_LANES];
   logic [ADDR_W-1:0]    startB   [NUM_LANES];
   logic [ADDR_W-1:0]    iterB    [NUM_LANES];
   vReadPkg::periodT     perB     [NUM_LANES];
   vReadPkg::periodT     dutyB    [NUM_LANES];
   vReadPkg::periodT     delayB   [NUM_LANES];
   logic [ADDR_W-1:0]    shiftB   [NUM_LANES];
   logic [ADDR_W-1:0]    incrB    [NUM_LANES];
   logic                 reverseB [NUM_LANES];
   logic                 memValid;
   vReadPkg::extAddrT    memAddr;
   logic                 memReady = 1'b0;
   logic [DATA_W-1:0]    memRdata = '0;
   logic [DATA_W-1:0]    outData  [NUM_LANES];
   logic [NUM_LANES-1:0] outValid;
   logic                 done;

   integer seed      = 32'h644f_1b4a;
   integer readySeed = 32'h644f_1b4a;
   int     errors    = 0;
   int     checks    = 0;
   int     cycleCnt  = 0;
   int     runCycle  = 0;
   int     xferCnt   = 0;
   int     xferExp   = 0;

   // lane model state
   logic [DATA_W-1:0] mirror    [NUM_LANES][DEPTH];
   logic [DATA_W-1:0] expQ      [NUM_LANES][$];
   logic              ppModel   [NUM_LANES];
   logic              firstSeen [NUM_LANES];

   vReadTop #(
      .NUM_LANES(NUM_LANES),
      .DATA_W   (DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_vReadTop (.*);

   initial clk = 1'b0;
   always #5 clk = !clk;

   always @(posedge clk)
   begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt >= MAX_CYCLES)
      begin
         $display("run stopped at the cycle limit of %0d without finishing", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   function automatic int unsigned randBelow(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // fixed scramble of the word address
   function automatic logic [DATA_W-1:0] memWord(input vReadPkg::extAddrT a);
      return {a ^ 16'hc3a5, (a << 3) + 16'h2b71};
   endfunction

   function automatic logic [ADDR_W-1:0] flipAddr(input logic [ADDR_W-1:0] a);
      logic [ADDR_W-1:0] r;
      r = {<<{a}};
      return r;
   endfunction

   // memory model with ready about 70% of cycles
   always @(negedge clk)
   begin
      memReady = ($unsigned($random(readySeed)) % 10) < 7;
      memRdata = memWord(memAddr);
      if (!rst && memValid && memReady)
      begin
         xferCnt++;
      end
   end

   always @(negedge clk)
   begin
      logic [DATA_W-1:0] expWord;
      if (!rst)
      begin
         for (int i = 0; i < NUM_LANES; i++)
         begin
            if (outValid[i])
            begin
               if (expQ[i].size() == 0)
               begin
                  errors++;
                  $display("lane %0d gave an extra word at time %0t", i, $time);
               end
               else
               begin
                  expWord = expQ[i].pop_front();
                  checks++;
                  assert (outData[i] == expWord)
                  else
                  begin
                     errors++;
                     $display("Fail at %0t: lane %0d read %h, expected %h",
                              $time, i, outData[i], expWord);
                  end
               end
               if (!firstSeen[i])
               begin
                  firstSeen[i] = 1'b1;
                  checks++;
                  assert (cycleCnt - runCycle == int'(delayB[i]) + 3)
                  else
                  begin
                     errors++;
                     $display("Fail at %0t: lane %0d first word after %0d cycles, delay %0d",
                              $time, i, cycleCnt - runCycle, delayB[i]);
                  end
               end
            end
         end
      end
   end

   task automatic clearLane(input int i);
      extAddr[i]  = '0;
      intAddr[i]  = '0;
      size[i]     = '0;
      iterA[i]    = '0;
      shiftA[i]   = '0;
      incrA[i]    = '0;
      pingPong[i] = 1'b0;
      startB[i]   = '0;
      iterB[i]    = '0;
      perB[i]     = '0;
      dutyB[i]    = '0;
      delayB[i]   = '0;
      shiftB[i]   = '0;
      incrB[i]    = '0;
      reverseB[i] = 1'b0;
   endtask

   task automatic randomPattern(input int i);
      startB[i]   = ADDR_W'(randBelow(DEPTH));
      iterB[i]    = ADDR_W'(randBelow(8) + 1);
      perB[i]     = vReadPkg::periodT'(randBelow(12) + 1);
      dutyB[i]    = vReadPkg::periodT'(randBelow(int'(perB[i]) + 1));
      delayB[i]   = vReadPkg::periodT'(randBelow(21));
      incrB[i]    = ADDR_W'(randBelow(DEPTH));
      shiftB[i]   = ADDR_W'(randBelow(DEPTH));
      reverseB[i] = (randBelow(2) == 1);
   endtask

   task automatic drawConfig(input int r);
      int kind;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         clearLane(i);
         if (r == 0)
         begin
            // fill the whole buffer
            extAddr[i] = vReadPkg::extAddrT'(randBelow(65536));
            size[i]    = vReadPkg::sizeT'(DEPTH);
         end
         else if (r == 1)
         begin
            // linear readback of the first load
            iterB[i] = ADDR_W'(8);
            perB[i]  = vReadPkg::periodT'(8);
            dutyB[i] = vReadPkg::periodT'(8);
            incrB[i] = ADDR_W'(1);
         end
         else
         begin
            kind = (r < 5) ? 2 : int'(randBelow(4));
            if (kind == 0)
            begin
               extAddr[i] = vReadPkg::extAddrT'(randBelow(65536));
               intAddr[i] = ADDR_W'(randBelow(DEPTH));
               size[i]    = vReadPkg::sizeT'(randBelow(DEPTH) + 1);
            end
            else
            begin
               randomPattern(i);
               pingPong[i] = (kind >= 2) || (randBelow(2) == 1);
               if (kind >= 2)
               begin
                  // fetch stays inside the half being filled
                  extAddr[i] = vReadPkg::extAddrT'(randBelow(65536));
                  intAddr[i] = ADDR_W'(randBelow(DEPTH));
                  size[i]    = vReadPkg::sizeT'(randBelow(DEPTH / 2 + 1 -
                                                int'(intAddr[i][ADDR_W-2:0])));
               end
            end
         end
      end
   endtask

   task automatic predictLane(input int i);
      logic              oldHalf;
      logic              newHalf;
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] ra;
      logic [ADDR_W-1:0] wa;
      oldHalf = ppModel[i];
      newHalf = pingPong[i] ? !oldHalf : 1'b0;
      // read stream from data already in the buffer
      a = startB[i];
      for (int it = 0; it < int'(iterB[i]); it++)
      begin
         for (int p = 0; p < int'(perB[i]); p++)
         begin
            if (p < int'(dutyB[i]))
            begin
               ra = reverseB[i] ? flipAddr(a) : a;
               if (pingPong[i])
               begin
                  ra[ADDR_W-1] = newHalf;
               end
               expQ[i].push_back(mirror[i][ra]);
               a = a + incrB[i];
            end
         end
         a = a + shiftB[i];
      end
      // fetch goes to the half marked before the toggle
      wa = intAddr[i];
      if (pingPong[i])
      begin
         wa[ADDR_W-1] = oldHalf;
      end
      for (int k = 0; k < int'(size[i]); k++)
      begin
         mirror[i][wa] = memWord(extAddr[i] + vReadPkg::extAddrT'(k));
         wa = wa + ADDR_W'(1);
      end
      xferExp += int'(size[i]);
      ppModel[i] = newHalf;
   endtask

   task automatic startRun(input int r);
      runCycle = cycleCnt;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         firstSeen[i] = 1'b0;
         predictLane(i);
      end
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      checks++;
      assert (!done)
      else
      begin
         errors++;
         $display("Fail at %0t: done still high after run %0d", $time, r);
      end
      while (!done)
      begin
         @(negedge clk);
      end
      checks++;
      assert (xferCnt == xferExp)
      else
      begin
         errors++;
         $display("Fail at %0t: %0d bus transfers, expected %0d", $time, xferCnt, xferExp);
      end
      // final word arrives together with done
      @(negedge clk);
      for (int i = 0; i < NUM_LANES; i++)
      begin
         if (expQ[i].size() != 0)
         begin
            errors++;
            $display("lane %0d is missing %0d words at the end of run %0d",
                     i, expQ[i].size(), r);
            expQ[i].delete();
         end
      end
   endtask

   initial
   begin
      rst = 1'b1;
      run = 1'b0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         clearLane(i);
         ppModel[i]   = 1'b0;
         firstSeen[i] = 1'b0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      checks++;
      assert (done && !memValid && (outValid == '0))
      else
      begin
         errors++;
         $display("Fail at %0t: outputs not idle after reset", $time);
      end
      for (int r = 0; r < NUM_RUNS; r++)
      begin
         drawConfig(r);
         startRun(r);
      end
      repeat (3) @(negedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* verif/vReadTb_assert.sv */
module vReadTb_assert #(
   parameter int NUM_LANES = 3
)
(
   input logic                 clk,
   input logic                 rst,
   input logic                 run,
   input logic                 memValid,
   input vReadPkg::extAddrT    memAddr,
   input logic                 memReady,
   input logic [NUM_LANES-1:0] outValid,
   input logic                 done
);

   // request holds while the memory stalls
   property busHold;
      @(posedge clk) disable iff (rst)
      (memValid && !memReady) |=> (memValid && $stable(memAddr));
   endproperty

   property doneFalls;
      @(posedge clk) disable iff (rst)
      run |=> !done;
   endproperty

   // last word may coincide with done rising
   property quietWhenDone;
      @(posedge clk) disable iff (rst)
      (done && (|outValid)) |-> $rose(done);
   endproperty

   assert property (busHold)
   else $error("memory request changed while memReady was low");

   assert property (doneFalls)
   else $error("done did not fall the cycle after run");

   assert property (quietWhenDone)
   else $error("a lane output was valid while done was already high");

endmodule

bind vReadTop vReadTb_assert #(
   .NUM_LANES(NUM_LANES)
) u_vReadTbAssert (
   .clk     (clk),
   .rst     (rst),
   .run     (run),
   .memValid(memValid),
   .memAddr (memAddr),
   .memReady(memReady),
   .outValid(outValid),
   .done    (done)
);
